/* flist.f */
hdl/conv_geom_pkg.sv
hdl/conv_data_pkg.sv
hdl/conv_scan_ctrl.sv
hdl/conv_weight_bank.sv
hdl/conv_window_mac.sv
hdl/conv_cal.sv
sim/tb_conv_cal.sv

/* hdl/conv_cal.sv */
// top level of the convolution engine, connects scan control, weight bank and MAC to the memories
`timescale 1ns/1ps

module conv_cal
        import conv_geom_pkg::*, conv_data_pkg::*;
(
        // system
        input  logic                    sclk,
        input  logic                    s_rst_n,
        input  logic                    cal_start,
        // image ram
        output logic [COL_AW-1:0]       data_rd_addr,
        output logic [ROW_AW-1:0]       row_cnt,
        input  pix_col_t                col_data,
        // parameter rom
        output logic [PARAM_AW-1:0]     param_rd_addr,
        output logic [KER_AW-1:0]       conv_cnt,               // also the bias address
        input  param_col_u              param_col,
        input  bias_t                   param_bias,
        // result
        output rslt_t                   conv_rslt_act,
        output logic                    conv_rslt_act_vld
);

        logic                           col_vld;
        logic                           wt_ld;
        logic                           bias_ld;
        logic                           win_last;
        param_col_u [KER_SIZE-1:0]      ker_w;
        bias_t                          ker_bias;

        // **************************************************
        // scan control
        // **************************************************
        conv_scan_ctrl u_scan_ctrl (
                .sclk           (sclk),
                .s_rst_n        (s_rst_n),
                .cal_start      (cal_start),
                .data_rd_addr   (data_rd_addr),
                .row_cnt        (row_cnt),
                .conv_cnt       (conv_cnt),
                .param_rd_addr  (param_rd_addr),
                .col_vld        (col_vld),
                .wt_ld          (wt_ld),
                .bias_ld        (bias_ld),
                .win_last       (win_last)
        );

        conv_weight_bank u_weight_bank (
                .sclk           (sclk),
                .s_rst_n        (s_rst_n),
                .wt_ld          (wt_ld),
                .bias_ld        (bias_ld),
                .param_col      (param_col),
                .param_bias     (param_bias),
                .ker_w          (ker_w),
                .ker_bias       (ker_bias)
        );

        // **************************************************
        // datapath
        // **************************************************
        conv_window_mac u_window_mac (
                .sclk                   (sclk),
                .s_rst_n                (s_rst_n),
                .col_vld                (col_vld),
                .win_last               (win_last),
                .col_data               (col_data),
                .ker_w                  (ker_w),
                .ker_bias               (ker_bias),
                .conv_rslt_act          (conv_rslt_act),
                .conv_rslt_act_vld      (conv_rslt_act_vld)
        );

endmodule

/* hdl/conv_data_pkg.sv */
// arithmetic types of the convolution datapath, used by the weight bank, the MAC and the top level
package conv_data_pkg;

        import conv_geom_pkg::*;

        // **************************************************
        // datapath widths
        // **************************************************
        localparam int WEIGHT_W = 16;                           // signed weight
        localparam int BIAS_W   = 16;                           // signed bias
        localparam int ACC_W    = 32;                           // sum of 25 taps plus bias

        // bit k is pixel row "row + k" of the column
        typedef logic [KER_SIZE-1:0]    pix_col_t;

        typedef logic signed [WEIGHT_W-1:0]     weight_t;
        typedef logic signed [BIAS_W-1:0]       bias_t;
        typedef logic signed [ACC_W-1:0]        acc_t;
        typedef logic [ACC_W-1:0]               rslt_t;         // after relu, never negative

        // one rom word seen flat at the port, or as the five taps of a kernel column
        typedef union packed {
                logic [KER_SIZE*WEIGHT_W-1:0]   flat;           // raw rom word
                weight_t [KER_SIZE-1:0]         tap;            // tap k weights kernel row k
        } param_col_u;

endpackage

/* hdl/conv_geom_pkg.sv */
// scan geometry and address widths of the convolution engine, imported by the RTL and testbench
package conv_geom_pkg;

        // **************************************************
        // kernel and image geometry
        // **************************************************
        localparam int KER_SIZE = 5;                            // kernel width and height
        localparam int IMG_COLS = 10;                           // words read per image row
        localparam int OUT_COLS = IMG_COLS - KER_SIZE + 1;      // window positions per row
        localparam int OUT_ROWS = 3;                            // output rows per kernel
        localparam int KER_NUM  = 2;                            // kernels per run

        // **************************************************
        // counter and address widths
        // **************************************************
        localparam int COL_AW   = 4;                            // image column address
        localparam int ROW_AW   = 2;                            // output row count
        localparam int KER_AW   = 1;                            // kernel index
        localparam int PARAM_AW = 4;                            // rom column address

        // both memories answer one cycle after the address
        localparam int RD_LAT   = 1;

endpackage

/* hdl/conv_scan_ctrl.sv */
// scan controller of the convolution engine, runs the address counters and the load strobes
`timescale 1ns/1ps

module conv_scan_ctrl
        import conv_geom_pkg::*;
(
        input  logic                    sclk,
        input  logic                    s_rst_n,
        input  logic                    cal_start,              // one cycle start strobe
        output logic [COL_AW-1:0]       data_rd_addr,
        output logic [ROW_AW-1:0]       row_cnt,
        output logic [KER_AW-1:0]       conv_cnt,
        output logic [PARAM_AW-1:0]     param_rd_addr,
        output logic                    col_vld,                // image word arriving
        output logic                    wt_ld,                  // kernel column arriving
        output logic                    bias_ld,                // first column of a kernel
        output logic                    win_last                // word completes a window
);

        logic                           conv_flag;              // run flag
        logic                           col_end;
        logic                           row_end;
        logic                           ker_end;
        logic                           run_end;

        logic                           flag_nxt;
        logic [COL_AW-1:0]              col_nxt;
        logic [ROW_AW-1:0]              row_nxt;
        logic [KER_AW-1:0]              ker_nxt;
        logic [PARAM_AW-1:0]            param_nxt;

        logic [3:0]                     phase_now;              // strobes of the shown address
        logic [RD_LAT-1:0][3:0]         phase_d;                // same, aligned to the data

        // **************************************************
        // counter stepping
        // **************************************************
        assign col_end = (data_rd_addr == COL_AW'(IMG_COLS - 1));
        assign row_end = (row_cnt == ROW_AW'(OUT_ROWS - 1));
        assign ker_end = (conv_cnt == KER_AW'(KER_NUM - 1));
        assign run_end = conv_flag && col_end && row_end && ker_end;   // last word of last kernel

        always_comb begin
                flag_nxt = conv_flag;
                col_nxt  = data_rd_addr;
                row_nxt  = row_cnt;
                ker_nxt  = conv_cnt;
                if (conv_flag == 1'b1) begin
                        if (run_end == 1'b1) begin
                                flag_nxt = 1'b0;                // back to rest, all zero
                                col_nxt  = '0;
                                row_nxt  = '0;
                                ker_nxt  = '0;
                        end else if (col_end == 1'b1) begin
                                col_nxt = '0;
                                if (row_end == 1'b1) begin
                                        row_nxt = '0;
                                        ker_nxt = conv_cnt + 1'b1;
                                end else begin
                                        row_nxt = row_cnt + 1'b1;
                                end
                        end else begin
                                col_nxt = data_rd_addr + 1'b1;
                        end
                end else if (cal_start == 1'b1) begin
                        flag_nxt = 1'b1;                        // start ignored while running
                end
        end

        // kernel columns are fetched along with the first five words of row 0
        always_comb begin
                if (flag_nxt == 1'b0)
                        param_nxt = '0;
                else if (row_nxt == '0 && col_nxt < COL_AW'(KER_SIZE))
                        param_nxt = PARAM_AW'(ker_nxt) * PARAM_AW'(KER_SIZE) + PARAM_AW'(col_nxt);
                else
                        param_nxt = param_rd_addr;              // hold
        end

        always_ff @(posedge sclk or negedge s_rst_n) begin
                if (s_rst_n == 1'b0) begin
                        conv_flag     <= 1'b0;
                        data_rd_addr  <= '0;
                        row_cnt       <= '0;
                        conv_cnt      <= '0;
                        param_rd_addr <= '0;
                end else begin
                        conv_flag     <= flag_nxt;
                        data_rd_addr  <= col_nxt;
                        row_cnt       <= row_nxt;
                        conv_cnt      <= ker_nxt;
                        param_rd_addr <= param_nxt;
                end
        end

        // **************************************************
        // phase strobes, delayed by the memory latency
        // **************************************************
        assign phase_now = {conv_flag,
                            conv_flag && row_cnt == '0 && data_rd_addr < COL_AW'(KER_SIZE),
                            conv_flag && row_cnt == '0 && data_rd_addr == '0,
                            conv_flag && data_rd_addr >= COL_AW'(IMG_COLS - OUT_COLS)};

        always_ff @(posedge sclk or negedge s_rst_n) begin
                if (s_rst_n == 1'b0) begin
                        phase_d <= '0;
                end else begin
                        for (int i = RD_LAT - 1; i > 0; i--) begin
                                phase_d[i] <= phase_d[i-1];
                        end
                        phase_d[0] <= phase_now;
                end
        end

        assign {col_vld, wt_ld, bias_ld, win_last} = phase_d[RD_LAT-1];

endmodule

/* hdl/conv_weight_bank.sv */
// weight bank of the convolution engine, holds the five kernel columns and the bias of one kernel
`timescale 1ns/1ps

module conv_weight_bank
        import conv_geom_pkg::*, conv_data_pkg::*;
(
        input  logic                            sclk,
        input  logic                            s_rst_n,
        input  logic                            wt_ld,          // kernel column on param_col
        input  logic                            bias_ld,        // kernel bias on param_bias
        input  param_col_u                      param_col,
        input  bias_t                           param_bias,
        output param_col_u [KER_SIZE-1:0]       ker_w,          // slot j is kernel column j
        output bias_t                           ker_bias
);

        // **************************************************
        // kernel columns
        // **************************************************
        // new column enters at the top slot, so the first of five ends in slot 0
        always_ff @(posedge sclk or negedge s_rst_n) begin
                if (s_rst_n == 1'b0) begin
                        ker_w <= '0;
                end else if (wt_ld == 1'b1) begin
                        ker_w <= {param_col, ker_w[KER_SIZE-1:1]};
                end
        end

        // **************************************************
        // bias
        // **************************************************
        // latched once per kernel, kept until the next kernel's first column
        always_ff @(posedge sclk or negedge s_rst_n) begin
                if (s_rst_n == 1'b0) begin
                        ker_bias <= '0;
                end else if (bias_ld == 1'b1) begin
                        ker_bias <= param_bias;
                end
        end

endmodule

/* hdl/conv_window_mac.sv */
// window and MAC of the convolution engine, sums the gated 5x5 taps with bias and applies relu
`timescale 1ns/1ps

module conv_window_mac
        import conv_geom_pkg::*, conv_data_pkg::*;
(
        input  logic                            sclk,
        input  logic                            s_rst_n,
        input  logic                            col_vld,        // image word on col_data
        input  logic                            win_last,       // this word closes a window
        input  pix_col_t                        col_data,
        input  param_col_u [KER_SIZE-1:0]       ker_w,
        input  bias_t                           ker_bias,
        output rslt_t                           conv_rslt_act,
        output logic                            conv_rslt_act_vld
);

        pix_col_t [KER_SIZE-1:0]        win_col;                // slot 0 is the oldest column
        logic                           win_rdy;                // window complete, sum next
        acc_t                           acc_sum;

        // **************************************************
        // pixel window
        // **************************************************
        always_ff @(posedge sclk) begin
                if (col_vld == 1'b1) begin
                        win_col <= {col_data, win_col[KER_SIZE-1:1]};
                end
        end

        always_ff @(posedge sclk or negedge s_rst_n) begin
                if (s_rst_n == 1'b0) begin
                        win_rdy <= 1'b0;
                end else begin
                        win_rdy <= win_last;
                end
        end

        // **************************************************
        // gated sum
        // **************************************************
        // a 1-bit pixel only selects its weight, no multiplier needed
        always_comb begin
                weight_t        tap_w;
                acc_sum = acc_t'(ker_bias);                     // sign extended bias
                for (int j = 0; j < KER_SIZE; j++) begin
                        for (int k = 0; k < KER_SIZE; k++) begin
                                tap_w = ker_w[j].tap[k];
                                if (win_col[j][k] == 1'b1) begin
                                        acc_sum = acc_sum + acc_t'(tap_w);
                                end
                        end
                end
        end

        // **************************************************
        // relu and result
        // **************************************************
        always_ff @(posedge sclk) begin
                if (win_rdy == 1'b1) begin
                        if (acc_sum[ACC_W-1] == 1'b1)
                                conv_rslt_act <= '0;            // negative sum clamps to zero
                        else
                                conv_rslt_act <= rslt_t'(acc_sum);
                end
        end

        always_ff @(posedge sclk or negedge s_rst_n) begin
                if (s_rst_n == 1'b0) begin
                        conv_rslt_act_vld <= 1'b0;
                end else begin
                        conv_rslt_act_vld <= win_rdy;           // one cycle strobe per window
                end
        end

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the convolution engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_conv_cal -f flist.f -o tb_conv_cal \
        > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/tb_conv_cal > sim.log 2>&1 || echo "simulator returned an error status"

! grep -q "=== FAIL ===" sim.log && grep -q "=== PASS ===" sim.log \
        && echo "simulation passed" \
        || { echo "simulation failed, see sim.log"; exit 1; }

/* sim/conv_trace.txt */
# tag and hex value per line: D image word (row-major), W 80-bit kernel column (tap 0 in low bits)
# B kernel bias (16-bit signed), E expected result (kernel, row, window column)
D 1a
D 13
D 1f
D 00
D 01
D 0c
D 15
D 0e
D 09
D 17
D 0d
D 19
D 1f
D 00
D 00
D 16
D 0a
D 17
D 04
D 1b
D 16
D 0c
D 1f
D 00
D 10
D 0b
D 05
D 1b
D 02
D 1d
# kernel 0 weights column j-2, kernel 1 weights row k as 2^k
W fffefffefffefffefffe
W ffffffffffffffffffff
W 00000000000000000000
W 00010001000100010001
W 00020002000200020002
W 00100008000400020001
W 00100008000400020001
W 00100008000400020001
W 00100008000400020001
W 00100008000400020001
B 000a
B ffc4
E 00000003
E 00000004
E 00000008
E 00000012
E 0000000d
E 0000000d
E 00000001
E 00000005
E 00000007
E 00000014
E 0000000d
E 0000000b
E 00000004
E 00000008
E 00000007
E 00000013
E 0000000b
E 0000000b
E 00000011
E 00000003
E 00000005
E 00000000
E 00000000
E 00000013
E 00000009
E 00000012
E 00000003
E 00000000
E 00000000
E 0000001a
E 00000015
E 0000000a
E 00000003
E 00000000
E 00000001
E 0000000e

/* sim/tb_conv_cal.sv */
// testbench of the convolution engine, replays the image and kernel trace and checks every result
`timescale 1ns/1ps

module tb_conv_cal
        import conv_geom_pkg::*, conv_data_pkg::*;
();

        localparam int IMG_WORDS  = OUT_ROWS * IMG_COLS;                // ram words
        localparam int PAR_WORDS  = KER_NUM * KER_SIZE;                 // rom kernel columns
        localparam int OUT_TOTAL  = KER_NUM * OUT_ROWS * OUT_COLS;      // results per run
        localparam int RUN_CYCLES = KER_NUM * OUT_ROWS * IMG_COLS;      // address cycles per run
        localparam int IDLE_MAX   = 64;                                 // longest gap before start
        localparam int CYC_LIMIT  = 2 * RUN_CYCLES + 2 * IDLE_MAX + 50;
        localparam int LATENCY    = 3;                                  // last address to valid

        logic                   sclk;
        logic                   s_rst_n;
        logic                   cal_start;
        logic [COL_AW-1:0]      data_rd_addr;
        logic [ROW_AW-1:0]      row_cnt;
        pix_col_t               col_data;
        logic [PARAM_AW-1:0]    param_rd_addr;
        logic [KER_AW-1:0]      conv_cnt;
        param_col_u             param_col;
        bias_t                  param_bias;
        rslt_t                  conv_rslt_act;
        logic                   conv_rslt_act_vld;

        pix_col_t               ram_mem [IMG_WORDS];
        param_col_u             rom_mem [PAR_WORDS];
        bias_t                  bias_mem [KER_NUM];
        rslt_t                  exp_mem [OUT_TOTAL];

        int                     rd_ram_idx;                     // addresses seen last cycle
        int                     rd_rom_idx;
        int                     rd_bias_idx;
        int                     cyc_cnt;
        int                     rslt_cnt;                       // results in the current run
        logic [LATENCY-1:0]     win_hist;                       // window addresses, newest at 0
        logic                   vld_exp;
        logic [31:0]            rnd_state;

        conv_cal dut (
                .sclk                   (sclk),
                .s_rst_n                (s_rst_n),
                .cal_start              (cal_start),
                .data_rd_addr           (data_rd_addr),
                .row_cnt                (row_cnt),
                .col_data               (col_data),
                .param_rd_addr          (param_rd_addr),
                .conv_cnt               (conv_cnt),
                .param_col              (param_col),
                .param_bias             (param_bias),
                .conv_rslt_act          (conv_rslt_act),
                .conv_rslt_act_vld      (conv_rslt_act_vld)
        );

        always #2 sclk = ~sclk;                                 // 4 ns period

        // **************************************************
        // helpers
        // **************************************************
        function automatic logic [31:0] xorshift32(input logic [31:0] s);
                s = s ^ (s << 13);
                s = s ^ (s >> 17);
                s = s ^ (s << 5);
                return s;
        endfunction

        task automatic stop_on_error(input string why);
                $display("%s", why);
                $display("=== FAIL ===");
                $fatal(1);
        endtask

        task automatic check_rslt(input string name, input rslt_t exp, input rslt_t act);
                if (act !== exp)
                        stop_on_error($sformatf("FAIL %s: expected %0d, actual %0d", name, exp, act));
        endtask

        task automatic check_param_addr(input string name, input logic [PARAM_AW-1:0] exp,
                                        input logic [PARAM_AW-1:0] act);
                if (act !== exp)
                        stop_on_error($sformatf("FAIL %s: expected %0d, actual %0d", name, exp, act));
        endtask

        task automatic check_count(input string name, input int exp, input int act);
                if (act != exp)
                        stop_on_error($sformatf("FAIL %s: expected %0d, actual %0d", name, exp, act));
        endtask

        // counters and rom address at rest
        task automatic check_rest(input string name);
                check_count({name, " data_rd_addr"}, 0, int'(data_rd_addr));
                check_count({name, " row_cnt"}, 0, int'(row_cnt));
                check_count({name, " conv_cnt"}, 0, int'(conv_cnt));
                check_param_addr({name, " param_rd_addr"}, '0, param_rd_addr);
        endtask

        task automatic load_trace();
                int                             fd;
                string                          line;
                logic [7:0]                     tag;
                logic [$bits(param_col_u)-1:0]  val;
                int                             n_d;
                int                             n_w;
                int                             n_b;
                int                             n_e;
                n_d = 0;
                n_w = 0;
                n_b = 0;
                n_e = 0;
                fd = $fopen("sim/conv_trace.txt", "r");
                if (fd == 0)
                        stop_on_error("could not open the trace file sim/conv_trace.txt");
                while ($fgets(line, fd) != 0) begin
                        if (line.len() < 2 || line.getc(0) == "#")
                                continue;               // comment or blank
                        if ($sscanf(line, "%c %h", tag, val) != 2)
                                stop_on_error($sformatf("unreadable trace line: %s", line));
                        case (tag)
                                "D": begin
                                        if (n_d < IMG_WORDS) ram_mem[n_d] = val[KER_SIZE-1:0];
                                        n_d++;
                                end
                                "W": begin
                                        if (n_w < PAR_WORDS) rom_mem[n_w].flat = val;
                                        n_w++;
                                end
                                "B": begin
                                        if (n_b < KER_NUM) bias_mem[n_b] = val[BIAS_W-1:0];
                                        n_b++;
                                end
                                "E": begin
                                        if (n_e < OUT_TOTAL) exp_mem[n_e] = val[ACC_W-1:0];
                                        n_e++;
                                end
                                default: stop_on_error($sformatf("unknown tag in trace: %s", line));
                        endcase
                end
                $fclose(fd);
                if (n_d != IMG_WORDS || n_w != PAR_WORDS || n_b != KER_NUM || n_e != OUT_TOTAL)
                        stop_on_error("trace file has the wrong number of D, W, B or E lines");
        endtask

        // random idle gap, one start strobe, optional extra strobes mid run
        task automatic run_once(input string name, input logic extra_starts);
                int gap;
                int start_cyc;
                rnd_state = xorshift32(rnd_state);
                gap = int'(rnd_state % 32'(IDLE_MAX));
                @(posedge sclk);
                rslt_cnt = 0;
                repeat (gap) @(posedge sclk);
                #1 cal_start = 1'b1;
                @(posedge sclk);
                start_cyc = cyc_cnt;                            // run starts with the next cycle
                #1 cal_start = 1'b0;
                if (extra_starts == 1'b1) begin
                        repeat (10) @(posedge sclk);
                        #1 cal_start = 1'b1;                    // must be ignored
                        @(posedge sclk);
                        #1 cal_start = 1'b0;
                        repeat (25) @(posedge sclk);
                        #1 cal_start = 1'b1;
                        @(posedge sclk);
                        #1 cal_start = 1'b0;
                end
                // last window address plus the result latency
                while (cyc_cnt < start_cyc + RUN_CYCLES + LATENCY) @(posedge sclk);
                repeat (4) @(negedge sclk);
                check_count({name, " result count"}, OUT_TOTAL, rslt_cnt);
                check_rest(name);
        endtask

        // **************************************************
        // memory models, registered read
        // **************************************************
        always @(posedge sclk) begin
                #1;
                col_data   = ram_mem[rd_ram_idx];
                param_col  = rom_mem[rd_rom_idx];
                param_bias = bias_mem[rd_bias_idx];
        end

        // **************************************************
        // monitor, sampled mid cycle
        // **************************************************
        always @(negedge sclk) begin
                cyc_cnt++;
                if (cyc_cnt > CYC_LIMIT)
                        stop_on_error($sformatf("timeout: test not finished after %0d cycles",
                                                CYC_LIMIT));
                rd_ram_idx  = int'(row_cnt) * IMG_COLS + int'(data_rd_addr);
                rd_rom_idx  = int'(param_rd_addr);
                rd_bias_idx = int'(conv_cnt);
                if (row_cnt == '0 && int'(data_rd_addr) < KER_SIZE)
                        check_param_addr("param_rd_addr",
                                         PARAM_AW'(int'(conv_cnt) * KER_SIZE + int'(data_rd_addr)),
                                         param_rd_addr);
                vld_exp = win_hist[LATENCY-1];
                if (conv_rslt_act_vld !== vld_exp) begin
                        if (vld_exp == 1'b1)
                                stop_on_error("result valid missing 3 cycles after a window address");
                        else
                                stop_on_error("result valid high with no window address 3 cycles before");
                end
                if (conv_rslt_act_vld === 1'b1) begin
                        if (rslt_cnt >= OUT_TOTAL)
                                stop_on_error("more results than windows in one run");
                        check_rslt($sformatf("result %0d", rslt_cnt), exp_mem[rslt_cnt],
                                   conv_rslt_act);
                        rslt_cnt++;
                end
                win_hist = {win_hist[LATENCY-2:0],
                            (int'(data_rd_addr) >= KER_SIZE - 1 && int'(data_rd_addr) < IMG_COLS)};
        end

        // **************************************************
        // test sequence
        // **************************************************
        initial begin
                sclk        = 1'b0;
                s_rst_n     = 1'b0;
                cal_start   = 1'b0;
                col_data    = '0;
                param_col   = '0;
                param_bias  = '0;
                rd_ram_idx  = 0;
                rd_rom_idx  = 0;
                rd_bias_idx = 0;
                cyc_cnt     = 0;
                rslt_cnt    = 0;
                win_hist    = '0;
                rnd_state   = 32'h3b5e_f3b0;
                load_trace();
                repeat (2) @(posedge sclk);
                #1 s_rst_n = 1'b1;
                repeat (3) @(negedge sclk);
                check_rest("after reset");
                run_once("first run", 1'b0);
                run_once("second run", 1'b1);
                $display("=== PASS ===");
                $finish;
        end

endmodule
